// File: run_sim.sh
#!/bin/sh
# build the hart testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module hart_tb -f sim.f > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vhart_tb > sim.log 2>&1
run_status=$?
cat sim.log
grep -q "Some tests failed" sim.log && { echo "simulation reported failures"; exit 1; }
[ "$run_status" -eq 0 ] || { echo "simulation stopped with an error"; exit 1; }
echo "simulation finished cleanly"

// File: sim.f
+incdir+src
src/hart_pkg.sv
src/decode_if.sv
src/decoder.sv
src/regfile.sv
src/exec_unit.sv
src/lsu.sv
src/hart.sv
tb/hart_chk.sv
tb/hart_tb.sv

// File: src/decode_if.sv
`timescale 1ns/1ps
`include "hart_defs.svh"

// decoded instruction fields and control flags, one instruction per cycle
interface decode_if;

    logic [2:0]              funct3;
    hart_pkg::alu_op_e       alu_op;
    logic [`HART_REG_AW-1:0] rs1;
    logic [`HART_REG_AW-1:0] rs2;
    logic [`HART_REG_AW-1:0] rd;
    logic [`HART_XLEN-1:0]   imm;

    // control flags, all active high
    logic rd_wen;
    logic alu_src_imm;
    logic is_load;
    logic is_store;
    logic is_branch;
    logic is_jal;
    logic is_jalr;
    logic is_lui;
    logic is_auipc;
    logic is_halt;

    modport producer (
        output funct3, alu_op, rs1, rs2, rd, imm,
        output rd_wen, alu_src_imm, is_load, is_store, is_branch,
        output is_jal, is_jalr, is_lui, is_auipc, is_halt
    );

    modport consumer (
        input funct3, alu_op, rs1, rs2, rd, imm,
        input rd_wen, alu_src_imm, is_load, is_store, is_branch,
        input is_jal, is_jalr, is_lui, is_auipc, is_halt
    );

endinterface

// File: src/decoder.sv
`timescale 1ns/1ps
`include "hart_defs.svh"

module decoder (
    input  logic [`HART_XLEN-1:0] i_inst,
    decode_if.producer            o_dec
);

    // ebreak is the only system instruction this hart recognizes
    localparam logic [`HART_XLEN-1:0] EBREAK_WORD = 32'h0010_0073;

    hart_pkg::opcode_e  opcode;
    hart_pkg::imm_fmt_e imm_fmt;
    logic [2:0]         funct3;
    logic [6:0]         funct7;

    assign opcode = hart_pkg::opcode_e'(i_inst[`HART_FLD_OPCODE]);
    assign funct3 = i_inst[`HART_FLD_FUNCT3];
    assign funct7 = i_inst[`HART_FLD_FUNCT7];

    // register fields sit at fixed positions in every format
    assign o_dec.funct3 = funct3;
    assign o_dec.rs1    = i_inst[`HART_FLD_RS1];
    assign o_dec.rs2    = i_inst[`HART_FLD_RS2];
    assign o_dec.rd     = i_inst[`HART_FLD_RD];

    // ====================
    // control flags
    // ====================
    always_comb begin
        o_dec.rd_wen      = 1'b0;
        o_dec.alu_src_imm = 1'b0;
        o_dec.is_load     = 1'b0;
        o_dec.is_store    = 1'b0;
        o_dec.is_branch   = 1'b0;
        o_dec.is_jal      = 1'b0;
        o_dec.is_jalr     = 1'b0;
        o_dec.is_lui      = 1'b0;
        o_dec.is_auipc    = 1'b0;
        o_dec.is_halt     = 1'b0;
        imm_fmt           = hart_pkg::IMM_I;
        // stores, branches and system words leave rd_wen clear
        case (opcode)
            hart_pkg::OPC_LOAD: begin
                o_dec.rd_wen      = 1'b1;
                o_dec.alu_src_imm = 1'b1;
                o_dec.is_load     = 1'b1;
            end
            hart_pkg::OPC_STORE: begin
                o_dec.alu_src_imm = 1'b1;
                o_dec.is_store    = 1'b1;
                imm_fmt           = hart_pkg::IMM_S;
            end
            hart_pkg::OPC_BRANCH: begin
                o_dec.is_branch = 1'b1;
                imm_fmt         = hart_pkg::IMM_B;
            end
            hart_pkg::OPC_JAL: begin
                o_dec.rd_wen = 1'b1;
                o_dec.is_jal = 1'b1;
                imm_fmt      = hart_pkg::IMM_J;
            end
            hart_pkg::OPC_JALR: begin
                o_dec.rd_wen      = 1'b1;
                o_dec.alu_src_imm = 1'b1;
                o_dec.is_jalr     = 1'b1;
            end
            hart_pkg::OPC_OP_IMM: begin
                o_dec.rd_wen      = 1'b1;
                o_dec.alu_src_imm = 1'b1;
            end
            hart_pkg::OPC_OP: o_dec.rd_wen = 1'b1;
            hart_pkg::OPC_LUI: begin
                o_dec.rd_wen = 1'b1;
                o_dec.is_lui = 1'b1;
                imm_fmt      = hart_pkg::IMM_U;
            end
            hart_pkg::OPC_AUIPC: begin
                o_dec.rd_wen   = 1'b1;
                o_dec.is_auipc = 1'b1;
                imm_fmt        = hart_pkg::IMM_U;
            end
            // any other system encoding simply falls through as a no-op
            hart_pkg::OPC_SYSTEM: o_dec.is_halt = (i_inst == EBREAK_WORD);
            default: ;
        endcase
    end

    // ====================
    // alu operation
    // ====================
    // memory, jalr and upper-immediate forms all need a plain add
    always_comb begin
        o_dec.alu_op = hart_pkg::ALU_ADD;
        if (opcode == hart_pkg::OPC_OP || opcode == hart_pkg::OPC_OP_IMM) begin
            case (funct3)
                // only the register form has a subtract, addi ignores bit 30
                3'b000: o_dec.alu_op = (opcode == hart_pkg::OPC_OP && funct7[5]) ?
                                       hart_pkg::ALU_SUB : hart_pkg::ALU_ADD;
                3'b001: o_dec.alu_op = hart_pkg::ALU_SLL;
                3'b010: o_dec.alu_op = hart_pkg::ALU_SLT;
                3'b011: o_dec.alu_op = hart_pkg::ALU_SLTU;
                3'b100: o_dec.alu_op = hart_pkg::ALU_XOR;
                3'b101: o_dec.alu_op = funct7[5] ? hart_pkg::ALU_SRA : hart_pkg::ALU_SRL;
                3'b110: o_dec.alu_op = hart_pkg::ALU_OR;
                default: o_dec.alu_op = hart_pkg::ALU_AND;
            endcase
        end
    end

    // ====================
    // immediate
    // ====================
    // bit 31 is the sign bit in every format
    always_comb begin
        case (imm_fmt)
            hart_pkg::IMM_S: o_dec.imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            hart_pkg::IMM_B: o_dec.imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7],
                                          i_inst[30:25], i_inst[11:8], 1'b0};
            hart_pkg::IMM_U: o_dec.imm = {i_inst[31:12], 12'b0};
            hart_pkg::IMM_J: o_dec.imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12],
                                          i_inst[20], i_inst[30:21], 1'b0};
            default:         o_dec.imm = {{20{i_inst[31]}}, i_inst[31:20]};
        endcase
    end

endmodule

// File: src/exec_unit.sv
`timescale 1ns/1ps
`include "hart_defs.svh"

module exec_unit (
    decode_if.consumer            i_dec,
    input  logic [`HART_XLEN-1:0] i_rs1,
    input  logic [`HART_XLEN-1:0] i_rs2,
    output logic [`HART_XLEN-1:0] o_result,
    output logic                  o_branch_taken
);

    logic [`HART_XLEN-1:0] op2;
    logic [4:0]            shamt;
    logic                  rs_eq;
    logic                  rs_lt;
    logic                  rs_ltu;
    logic                  cond;

    // immediate forms, loads, stores and jalr take the immediate as operand b
    assign op2   = i_dec.alu_src_imm ? i_dec.imm : i_rs2;
    assign shamt = op2[4:0];

    always_comb begin
        case (i_dec.alu_op)
            hart_pkg::ALU_SUB:  o_result = i_rs1 - op2;
            hart_pkg::ALU_SLL:  o_result = i_rs1 << shamt;
            hart_pkg::ALU_SLT:  o_result = {31'b0, $signed(i_rs1) < $signed(op2)};
            hart_pkg::ALU_SLTU: o_result = {31'b0, i_rs1 < op2};
            hart_pkg::ALU_XOR:  o_result = i_rs1 ^ op2;
            hart_pkg::ALU_SRL:  o_result = i_rs1 >> shamt;
            hart_pkg::ALU_SRA:  o_result = $signed(i_rs1) >>> shamt;
            hart_pkg::ALU_OR:   o_result = i_rs1 | op2;
            hart_pkg::ALU_AND:  o_result = i_rs1 & op2;
            default:            o_result = i_rs1 + op2;
        endcase
    end

    // branches always compare the two registers, never the immediate
    assign rs_eq  = (i_rs1 == i_rs2);
    assign rs_lt  = ($signed(i_rs1) < $signed(i_rs2));
    assign rs_ltu = (i_rs1 < i_rs2);

    // funct3 bit 0 inverts the base condition of each pair
    always_comb begin
        case (i_dec.funct3)
            3'b000:  cond = rs_eq;
            3'b001:  cond = !rs_eq;
            3'b100:  cond = rs_lt;
            3'b101:  cond = !rs_lt;
            3'b110:  cond = rs_ltu;
            3'b111:  cond = !rs_ltu;
            default: cond = 1'b0;
        endcase
    end

    assign o_branch_taken = i_dec.is_branch && cond;

endmodule

// File: src/hart.sv
`timescale 1ns/1ps
`include "hart_defs.svh"

module hart (
    input  logic                    i_clk,
    input  logic                    i_rst,
    // instruction port, the word comes back in the same cycle
    output logic [`HART_XLEN-1:0]   o_imem_raddr,
    input  logic [`HART_XLEN-1:0]   i_imem_rdata,
    // data port, reads are combinational and writes land on the next edge
    output logic [`HART_XLEN-1:0]   o_dmem_addr,
    output logic                    o_dmem_ren,
    output logic                    o_dmem_wen,
    output logic [`HART_XLEN-1:0]   o_dmem_wdata,
    output logic [3:0]              o_dmem_mask,
    input  logic [`HART_XLEN-1:0]   i_dmem_rdata,
    // retire report for the instruction executing this cycle
    output logic                    o_retire_valid,
    output logic [`HART_XLEN-1:0]   o_retire_inst,
    output logic [`HART_XLEN-1:0]   o_retire_pc,
    output logic [`HART_XLEN-1:0]   o_retire_next_pc,
    output logic [`HART_REG_AW-1:0] o_retire_rd_waddr,
    output logic [`HART_XLEN-1:0]   o_retire_rd_wdata,
    output logic                    o_retire_halt
);

    logic [`HART_XLEN-1:0] pc;
    logic [`HART_XLEN-1:0] next_pc;
    logic [`HART_XLEN-1:0] pc_plus_4;
    logic [`HART_XLEN-1:0] pc_plus_imm;
    logic [`HART_XLEN-1:0] rs1_rdata;
    logic [`HART_XLEN-1:0] rs2_rdata;
    logic [`HART_XLEN-1:0] alu_result;
    logic [`HART_XLEN-1:0] load_data;
    logic [`HART_XLEN-1:0] rd_wdata;
    logic                  branch_taken;

    decode_if dec ();

    // ====================
    // fetch and pc
    // ====================
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc <= `HART_RESET_ADDR;
        end else begin
            pc <= next_pc;
        end
    end

    assign o_imem_raddr = pc;
    assign pc_plus_4    = pc + 32'd4;
    assign pc_plus_imm  = pc + dec.imm;

    // jalr goes first since it is the only target taken from a register
    always_comb begin
        if (dec.is_jalr) begin
            next_pc = {alu_result[`HART_XLEN-1:1], 1'b0};
        end else if (dec.is_jal || branch_taken) begin
            next_pc = pc_plus_imm;
        end else begin
            next_pc = pc_plus_4;
        end
    end

    // ====================
    // datapath
    // ====================
    decoder u_decoder (
        .i_inst (i_imem_rdata),
        .o_dec  (dec.producer)
    );

    regfile u_regfile (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_rs1_addr  (dec.rs1),
        .i_rs2_addr  (dec.rs2),
        .i_rd_wen    (dec.rd_wen),
        .i_rd_addr   (dec.rd),
        .i_rd_wdata  (rd_wdata),
        .o_rs1_rdata (rs1_rdata),
        .o_rs2_rdata (rs2_rdata)
    );

    exec_unit u_exec (
        .i_dec          (dec.consumer),
        .i_rs1          (rs1_rdata),
        .i_rs2          (rs2_rdata),
        .o_result       (alu_result),
        .o_branch_taken (branch_taken)
    );

    // the alu sum of rs1 and the immediate is the effective address
    lsu u_lsu (
        .i_rst        (i_rst),
        .i_dec        (dec.consumer),
        .i_addr       (alu_result),
        .i_store_data (rs2_rdata),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_ren   (o_dmem_ren),
        .o_dmem_wen   (o_dmem_wen),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_mask  (o_dmem_mask),
        .o_load_data  (load_data)
    );

    // ====================
    // writeback
    // ====================
    always_comb begin
        if (dec.is_lui) begin
            rd_wdata = dec.imm;
        end else if (dec.is_auipc) begin
            rd_wdata = pc_plus_imm;
        end else if (dec.is_jal || dec.is_jalr) begin
            // link address
            rd_wdata = pc_plus_4;
        end else if (dec.is_load) begin
            rd_wdata = load_data;
        end else begin
            rd_wdata = alu_result;
        end
    end

    // ====================
    // retire
    // ====================
    // one instruction retires in every cycle outside reset
    assign o_retire_valid    = !i_rst;
    assign o_retire_inst     = i_imem_rdata;
    assign o_retire_pc       = pc;
    assign o_retire_next_pc  = next_pc;
    // rd reads zero for anything that does not write a register
    assign o_retire_rd_waddr = dec.rd_wen ? dec.rd : '0;
    assign o_retire_rd_wdata = rd_wdata;
    assign o_retire_halt     = dec.is_halt;

endmodule

// File: src/hart_defs.svh
`ifndef HART_DEFS_SVH
`define HART_DEFS_SVH

// data path and address width of the hart
`define HART_XLEN       32

// architectural register file geometry
`define HART_REG_COUNT  32
`define HART_REG_AW     5

// first fetch address once reset is released
`define HART_RESET_ADDR 32'h0000_0000

// bit ranges of the fixed instruction fields, used as inst[`HART_FLD_x]
`define HART_FLD_OPCODE 6:0
`define HART_FLD_RD     11:7
`define HART_FLD_FUNCT3 14:12
`define HART_FLD_RS1    19:15
`define HART_FLD_RS2    24:20
`define HART_FLD_FUNCT7 31:25

`endif

// File: src/hart_pkg.sv
package hart_pkg;

    // major opcodes of the RV32I base set, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b000_0011,
        OPC_STORE  = 7'b010_0011,
        OPC_BRANCH = 7'b110_0011,
        OPC_JAL    = 7'b110_1111,
        OPC_JALR   = 7'b110_0111,
        OPC_OP_IMM = 7'b001_0011,
        OPC_OP     = 7'b011_0011,
        OPC_LUI    = 7'b011_0111,
        OPC_AUIPC  = 7'b001_0111,
        OPC_SYSTEM = 7'b111_0011
    } opcode_e;

    // operations the execute unit can perform on its two operands
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // immediate layouts, R type carries no immediate
    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

endpackage

// File: src/lsu.sv
`timescale 1ns/1ps
`include "hart_defs.svh"

module lsu (
    input  logic                  i_rst,
    decode_if.consumer            i_dec,
    input  logic [`HART_XLEN-1:0] i_addr,
    input  logic [`HART_XLEN-1:0] i_store_data,
    input  logic [`HART_XLEN-1:0] i_dmem_rdata,
    output logic [`HART_XLEN-1:0] o_dmem_addr,
    output logic                  o_dmem_ren,
    output logic                  o_dmem_wen,
    output logic [`HART_XLEN-1:0] o_dmem_wdata,
    output logic [3:0]            o_dmem_mask,
    output logic [`HART_XLEN-1:0] o_load_data
);

    logic [1:0]            offset;
    logic [4:0]            lane_shift;
    logic [`HART_XLEN-1:0] lane_data;

    // the memory only sees word addresses, the low bits pick the lanes
    assign offset      = i_addr[1:0];
    assign lane_shift  = {offset, 3'b000};
    assign o_dmem_addr = {i_addr[`HART_XLEN-1:2], 2'b00};

    assign o_dmem_ren = i_dec.is_load;
    // a store must not reach memory while the hart is held in reset
    assign o_dmem_wen = i_dec.is_store && !i_rst;

    // funct3[1:0] gives the size for loads and stores alike
    always_comb begin
        case (i_dec.funct3[1:0])
            2'b00:   o_dmem_mask = 4'b0001 << offset;
            2'b01:   o_dmem_mask = offset[1] ? 4'b1100 : 4'b0011;
            default: o_dmem_mask = 4'b1111;
        endcase
    end

    // byte and half stores move up to their lane, the mask hides the rest
    assign o_dmem_wdata = i_store_data << lane_shift;

    // loads bring the addressed lane down to bit 0 before extension
    assign lane_data = i_dmem_rdata >> lane_shift;

    // funct3[2] set means lbu or lhu
    always_comb begin
        case (i_dec.funct3[1:0])
            2'b00: begin
                o_load_data = i_dec.funct3[2] ? {24'b0, lane_data[7:0]}
                                              : {{24{lane_data[7]}}, lane_data[7:0]};
            end
            2'b01: begin
                o_load_data = i_dec.funct3[2] ? {16'b0, lane_data[15:0]}
                                              : {{16{lane_data[15]}}, lane_data[15:0]};
            end
            default: o_load_data = lane_data;
        endcase
    end

endmodule

// File: src/regfile.sv
`timescale 1ns/1ps
`include "hart_defs.svh"

module regfile (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic [`HART_REG_AW-1:0] i_rs1_addr,
    input  logic [`HART_REG_AW-1:0] i_rs2_addr,
    input  logic                    i_rd_wen,
    input  logic [`HART_REG_AW-1:0] i_rd_addr,
    input  logic [`HART_XLEN-1:0]   i_rd_wdata,
    output logic [`HART_XLEN-1:0]   o_rs1_rdata,
    output logic [`HART_XLEN-1:0]   o_rs2_rdata
);

    logic [`HART_XLEN-1:0] regs [`HART_REG_COUNT];

    // reset wins over a write, so nothing lands while the hart is held
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `HART_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && (i_rd_addr != '0)) begin
            // x0 is hardwired, writes to it are dropped
            regs[i_rd_addr] <= i_rd_wdata;
        end
    end

    // asynchronous reads, a write shows up only after the next edge
    // x0 is forced here too so it reads zero even before the first reset
    assign o_rs1_rdata = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_rdata = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

// File: tb/hart_chk.sv
`timescale 1ns/1ps
`include "hart_defs.svh"

// port rules of the hart, attached to the hart module from the testbench
module hart_chk (
    input logic                  i_clk,
    input logic                  i_rst,
    input logic [`HART_XLEN-1:0] i_imem_raddr,
    input logic [`HART_XLEN-1:0] i_dmem_addr,
    input logic                  i_dmem_ren,
    input logic                  i_dmem_wen,
    input logic                  i_retire_valid
);

    // one instruction is a load or a store, never both
    dmem_one_direction: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_dmem_ren && i_dmem_wen))
        else $error("data port read and write enables are both high");

    // both ports only ever carry word addresses
    imem_word_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        i_imem_raddr[1:0] == 2'b00)
        else $error("instruction address %h is not word aligned", i_imem_raddr);

    dmem_word_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        i_dmem_addr[1:0] == 2'b00)
        else $error("data address %h is not word aligned", i_dmem_addr);

    // nothing retires while the hart is held in reset
    no_retire_in_reset: assert property (@(posedge i_clk) i_rst |-> !i_retire_valid)
        else $error("retire valid is high during reset");

endmodule

// File: tb/hart_tb.sv
`timescale 1ns/1ps
`include "hart_defs.svh"

module hart_tb;

    localparam int    MEM_WORDS   = 64;
    localparam int    MAX_RECORDS = 64;
    localparam string TESTS_FILE  = "tb/hart_tests.txt";

    logic                    clk;
    logic                    rst;
    logic [`HART_XLEN-1:0]   imem_raddr;
    logic [`HART_XLEN-1:0]   imem_rdata;
    logic [`HART_XLEN-1:0]   dmem_addr;
    logic                    dmem_ren;
    logic                    dmem_wen;
    logic [`HART_XLEN-1:0]   dmem_wdata;
    logic [3:0]              dmem_mask;
    logic [`HART_XLEN-1:0]   dmem_rdata;
    logic                    retire_valid;
    logic [`HART_XLEN-1:0]   retire_inst;
    logic [`HART_XLEN-1:0]   retire_pc;
    logic [`HART_XLEN-1:0]   retire_next_pc;
    logic [`HART_REG_AW-1:0] retire_rd_waddr;
    logic [`HART_XLEN-1:0]   retire_rd_wdata;
    logic                    retire_halt;

    // word arrays indexed by address bits 7:2
    logic [`HART_XLEN-1:0] imem [MEM_WORDS];
    logic [`HART_XLEN-1:0] dmem [MEM_WORDS];

    // expected retire records in retire order
    logic [`HART_XLEN-1:0]   exp_pc      [MAX_RECORDS];
    logic [`HART_XLEN-1:0]   exp_next_pc [MAX_RECORDS];
    logic [`HART_REG_AW-1:0] exp_rd      [MAX_RECORDS];
    logic [`HART_XLEN-1:0]   exp_rd_data [MAX_RECORDS];

    int n_records;
    int rec_idx;
    int n_pass;
    int n_fail;
    int cycles;
    bit done;

    always #10 clk = ~clk;

    // ====================
    // memory models
    // ====================
    assign imem_rdata = imem[imem_raddr[7:2]];
    // the data memory only returns a word while the hart requests a read
    assign dmem_rdata = dmem_ren ? dmem[dmem_addr[7:2]] : '0;

    // data memory clears while reset is held and stores land per byte lane on the edge
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (dmem_wen) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_mask[b]) begin
                    dmem[dmem_addr[7:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
                end
            end
        end
    end

    hart i_hart (
        .i_clk             (clk),
        .i_rst             (rst),
        .o_imem_raddr      (imem_raddr),
        .i_imem_rdata      (imem_rdata),
        .o_dmem_addr       (dmem_addr),
        .o_dmem_ren        (dmem_ren),
        .o_dmem_wen        (dmem_wen),
        .o_dmem_wdata      (dmem_wdata),
        .o_dmem_mask       (dmem_mask),
        .i_dmem_rdata      (dmem_rdata),
        .o_retire_valid    (retire_valid),
        .o_retire_inst     (retire_inst),
        .o_retire_pc       (retire_pc),
        .o_retire_next_pc  (retire_next_pc),
        .o_retire_rd_waddr (retire_rd_waddr),
        .o_retire_rd_wdata (retire_rd_wdata),
        .o_retire_halt     (retire_halt)
    );

    bind hart hart_chk u_hart_chk (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_imem_raddr   (o_imem_raddr),
        .i_dmem_addr    (o_dmem_addr),
        .i_dmem_ren     (o_dmem_ren),
        .i_dmem_wen     (o_dmem_wen),
        .i_retire_valid (o_retire_valid)
    );

    // ====================
    // tests file loader
    // ====================
    // P lines fill the instruction memory and E lines append an expected record
    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        byte         kind;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            $display("could not open %s", TESTS_FILE);
            n_fail++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%c %h %h %h %h", kind, f1, f2, f3, f4);
            if (kind == "P" && n >= 3) begin
                imem[f1[7:2]] = f2;
            end else if (kind == "E" && n == 5 && n_records < MAX_RECORDS) begin
                exp_pc[n_records]      = f1;
                exp_next_pc[n_records] = f2;
                exp_rd[n_records]      = f3[`HART_REG_AW-1:0];
                exp_rd_data[n_records] = f4;
                n_records++;
            end
        end
        $fclose(fd);
    endtask

    // ====================
    // retire checking
    // ====================
    task automatic check_retire();
        bit ok;
        ok = 1'b1;
        if (rec_idx >= n_records) begin
            $display("pc 0x%08h retired but no expected record is left", retire_pc);
            n_fail++;
            done = 1'b1;
            return;
        end
        if (retire_pc !== exp_pc[rec_idx]) begin
            $display("MISMATCH o_retire_pc: got 0x%08h expected 0x%08h",
                     retire_pc, exp_pc[rec_idx]);
            ok = 1'b0;
        end
        // the instruction must be the program word stored at the expected pc
        if (retire_inst !== imem[exp_pc[rec_idx][7:2]]) begin
            $display("MISMATCH o_retire_inst: got 0x%08h expected 0x%08h",
                     retire_inst, imem[exp_pc[rec_idx][7:2]]);
            ok = 1'b0;
        end
        if (retire_next_pc !== exp_next_pc[rec_idx]) begin
            $display("MISMATCH o_retire_next_pc: got 0x%08h expected 0x%08h",
                     retire_next_pc, exp_next_pc[rec_idx]);
            ok = 1'b0;
        end
        if (retire_rd_waddr !== exp_rd[rec_idx]) begin
            $display("MISMATCH o_retire_rd_waddr: got 0x%02h expected 0x%02h",
                     retire_rd_waddr, exp_rd[rec_idx]);
            ok = 1'b0;
        end
        // rd data only carries meaning when a register is written
        if (exp_rd[rec_idx] != '0 && retire_rd_wdata !== exp_rd_data[rec_idx]) begin
            $display("MISMATCH o_retire_rd_wdata: got 0x%08h expected 0x%08h",
                     retire_rd_wdata, exp_rd_data[rec_idx]);
            ok = 1'b0;
        end
        if (ok) begin
            n_pass++;
            $display("test %0d at pc 0x%08h ok", rec_idx + 1, exp_pc[rec_idx]);
        end else begin
            n_fail++;
            $display("test %0d at pc 0x%08h FAILED", rec_idx + 1, exp_pc[rec_idx]);
        end
        rec_idx++;
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        clk       = 1'b0;
        rst      <= 1'b1;
        n_records = 0;
        rec_idx   = 0;
        n_pass    = 0;
        n_fail    = 0;
        cycles    = 0;
        done      = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
        end
        load_tests();
        if (n_records == 0) begin
            $display("no expected records were found in the tests file");
            n_fail++;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // retire outputs settle after the edge and are sampled mid-cycle
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (retire_valid) begin
                check_retire();
            end
            if (!done && retire_valid && retire_halt) begin
                done = 1'b1;
                if (rec_idx != n_records) begin
                    $display("halt reached with %0d expected records unused",
                             n_records - rec_idx);
                    n_fail++;
                end
            end else if (!done && cycles >= n_records + 20) begin
                $display("no halt within %0d cycles, run stopped", cycles);
                n_fail++;
                done = 1'b1;
            end
        end
        $display("%0d checks passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: tb/hart_tests.txt
# P <byte address> <instruction word>, program lines for the instruction memory
# E <pc> <next pc> <rd address> <rd data> in retire order, rd data unused when rd is 0
P 00 876540b7  # lui   x1, 0x87654
P 04 00001117  # auipc x2, 0x1
P 08 ff800193  # addi  x3, x0, -8
P 0c 403082b3  # sub   x5, x1, x3
P 10 4021d313  # srai  x6, x3, 2
P 14 0041d393  # srli  x7, x3, 4
P 18 0001a433  # slt   x8, x3, x0
P 1c 0001b4b3  # sltu  x9, x3, x0
P 20 04202023  # sw    x2, 0x40(x0)
P 24 047000a3  # sb    x7, 0x41(x0)
P 28 04301123  # sh    x3, 0x42(x0)
P 2c 04100503  # lb    x10, 0x41(x0)
P 30 04104583  # lbu   x11, 0x41(x0)
P 34 04201603  # lh    x12, 0x42(x0)
P 38 04205683  # lhu   x13, 0x42(x0)
P 3c 04002703  # lw    x14, 0x40(x0)
P 40 00940463  # beq   x8, x9, +8   not taken
P 44 00048463  # beq   x9, x0, +8   taken
P 4c 00049463  # bne   x9, x0, +8   not taken
P 50 00941463  # bne   x8, x9, +8   taken
P 58 00344463  # blt   x8, x3, +8   not taken
P 5c 0081c463  # blt   x3, x8, +8   taken
P 64 00347463  # bgeu  x8, x3, +8   not taken
P 68 0081f463  # bgeu  x3, x8, +8   taken
P 70 008007ef  # jal   x15, +8
P 78 00d78867  # jalr  x16, 13(x15) odd sum
P 80 00100073  # ebreak
E 00 04 01 87654000
E 04 08 02 00001004
E 08 0c 03 fffffff8
E 0c 10 05 87654008
E 10 14 06 fffffffe
E 14 18 07 0fffffff
E 18 1c 08 00000001
E 1c 20 09 00000000
E 20 24 00 00000000
E 24 28 00 00000000
E 28 2c 00 00000000
E 2c 30 0a ffffffff
E 30 34 0b 000000ff
E 34 38 0c fffffff8
E 38 3c 0d 0000fff8
E 3c 40 0e fff8ff04
E 40 44 00 00000000
E 44 4c 00 00000000
E 4c 50 00 00000000
E 50 58 00 00000000
E 58 5c 00 00000000
E 5c 64 00 00000000
E 64 68 00 00000000
E 68 70 00 00000000
E 70 78 0f 00000074
E 78 80 10 0000007c
E 80 84 00 00000000
